/* column_flattener.f */
logic/raster_pkg.sv
logic/palette_pkg.sv
logic/column_sequencer.sv
logic/wall_span.sv
logic/wall_palette.sv
logic/pixel_assembler.sv
logic/column_flattener.sv
tb/column_flattener_tb.sv

/* Makefile */
TOP := column_flattener_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f column_flattener.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* tb/column_flattener_tb.sv */
`timescale 1ns/1ps

module column_flattener_tb;
    import raster_pkg::*;
    import palette_pkg::*;

    localparam int SCREEN_WIDTH    = 320;
    localparam int SCREEN_HEIGHT   = 180;
    localparam int NUM_PACKETS     = 4;  // one packet per theme
    localparam int COLS_PER_PACKET = 4;
    localparam int NUM_COLS        = NUM_PACKETS * COLS_PER_PACKET;
    localparam int WATCHDOG_CYCLES = NUM_COLS * SCREEN_HEIGHT * 4 + 1000;

    logic        pixel_clk_in = 1'b0;
    logic        rst_in;
    logic        col_valid;
    logic        col_ready;
    ray_col_t    col_data;
    logic        col_last;
    theme_t      theme;
    logic [1:0]  fb_swap_ok;
    logic        pix_valid;
    fb_pixel_t   pix_data;
    logic        pix_ready;

    logic [15:0] lfsr_state = 16'd34;
    logic        ready_random = 1'b0;  // 0 keeps pix_ready high
    ray_col_t    rec_q[$];             // accepted records in arrival order
    logic        last_q[$];
    theme_t      theme_q[$];
    int          row_cnt = 0;          // row of rec_q[0] expected next
    int          pix_count = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    logic        stalled = 1'b0;
    fb_pixel_t   held_pix;
    fb_pixel_t   exp_pix;

    column_flattener #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) dut (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .col_valid    (col_valid),
        .col_ready    (col_ready),
        .col_data     (col_data),
        .col_last     (col_last),
        .theme        (theme),
        .fb_swap_ok   (fb_swap_ok),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .pix_ready    (pix_ready)
    );

    always #20 pixel_clk_in = ~pixel_clk_in;  // 40 ns period

    // 16-bit galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // expected beat for row r of a record
    function automatic fb_pixel_t expected_pixel(input ray_col_t rec, input int r,
                                                 input theme_t th, input logic rec_last);
        fb_pixel_t   p;
        pixel_word_t wall_w;
        logic [7:0]  sky_c;
        logic [7:0]  ground_c;
        int          half_h;
        int          top;
        int          bottom;
        half_h = int'(rec.line_height) / 2;
        top    = SCREEN_HEIGHT / 2 - half_h;
        bottom = SCREEN_HEIGHT / 2 + half_h;
        if (top < 0) top = 0;                    // tall walls clip at the screen edge
        if (bottom > SCREEN_HEIGHT) bottom = SCREEN_HEIGHT;
        sky_c    = 8'd38;                        // pigs and dino
        ground_c = 8'd45;
        if (th == HEDGE) begin
            sky_c    = 8'd249;
            ground_c = 8'd239;
        end else if (th == NEON) begin
            sky_c    = 8'd0;
            ground_c = 8'd0;
        end
        wall_w.shade = rec.y_side;
        case (rec.map_val)
            5'd0:    wall_w = '{1'b0, sky_c};    // open cell shows unshaded sky
            5'd23:   wall_w.colour = 8'd21;
            5'd24:   wall_w.colour = 8'd48;
            5'd25:   wall_w.colour = 8'd32;
            5'd26:   wall_w.colour = 8'd181;
            default: wall_w.colour = 8'd14;      // plain wall
        endcase
        if (r < top) p.pixel = '{1'b0, sky_c};
        else if (r >= bottom) p.pixel = '{1'b0, ground_c};
        else p.pixel = wall_w;
        p.addr = fb_addr_t'(int'(rec.col) + r * SCREEN_WIDTH);
        p.last = rec_last && (r == SCREEN_HEIGHT - 1);
        return p;
    endfunction

    task automatic report_protocol_error(input string what);
        protocol_errors++;
        $display("error: %s", what);
    endtask

    task automatic check_pixel(input pixel_word_t got, input pixel_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] pix_data.pixel got %h expected %h (row %0d)", got, exp, row_cnt);
        end
    endtask

    task automatic check_addr(input fb_addr_t got, input fb_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] pix_data.addr got %h expected %h (row %0d)", got, exp, row_cnt);
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] pix_data.last got %h expected %h (row %0d)", got, exp, row_cnt);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d value, %0d protocol, %0d pixels received",
                 value_errors, protocol_errors, pix_count);
    endtask

    // every accepted pixel is compared with the head of the queue
    always @(posedge pixel_clk_in) begin
        if (!rst_in) begin
            if (stalled && (!pix_valid || pix_data !== held_pix)) begin
                report_protocol_error("output pixel dropped or changed while stalled");
            end
            stalled  = pix_valid && !pix_ready;
            held_pix = pix_data;
            if (pix_valid && pix_ready) begin
                pix_count++;  // every transfer counts, matched or not
                if (rec_q.size() == 0) begin
                    report_protocol_error("pixel arrived with no record pending");
                end else begin
                    exp_pix = expected_pixel(rec_q[0], row_cnt, theme_q[0], last_q[0]);
                    check_pixel(pix_data.pixel, exp_pix.pixel);
                    check_addr(pix_data.addr, exp_pix.addr);
                    check_last(pix_data.last, exp_pix.last);
                    row_cnt++;
                    if (row_cnt == SCREEN_HEIGHT) begin  // column complete
                        row_cnt = 0;
                        void'(rec_q.pop_front());
                        void'(last_q.pop_front());
                        void'(theme_q.pop_front());
                    end
                end
            end
        end
    end

    // wait one clock and drive 2 ns after the edge
    task automatic step();
        logic [31:0] b;
        @(posedge pixel_clk_in);
        #2;
        draw_bits(1, b);
        pix_ready = ready_random ? b[0] : 1'b1;
    endtask

    task automatic make_record(input int idx, output ray_col_t rec);
        logic [31:0] b;
        draw_bits(9, b);
        rec.col = col_t'(b % SCREEN_WIDTH);
        draw_bits(8, b);
        rec.line_height = b[7:0];
        if (idx % 4 == 1) rec.line_height = 8'd0;     // no wall
        if (idx % 4 == 2) rec.line_height = 8'd255;   // clipped both ends
        draw_bits(1, b);
        rec.y_side = b[0];
        draw_bits(16, b);
        rec.wall_x = b[15:0];                         // carried but never drawn
        case (idx)
            0:       rec.map_val = 5'd0;
            1:       rec.map_val = 5'd1;
            2:       rec.map_val = 5'd5;
            3:       rec.map_val = 5'd23;
            4:       rec.map_val = 5'd24;
            5:       rec.map_val = 5'd25;
            6:       rec.map_val = 5'd26;
            7:       rec.map_val = 5'd31;
            default: begin
                draw_bits(5, b);
                rec.map_val = b[4:0];
            end
        endcase
    endtask

    task automatic send_col(input ray_col_t rec, input logic is_last);
        logic accepted;
        col_data  = rec;
        col_last  = is_last;
        col_valid = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            accepted = col_ready;  // ready seen here still holds at the coming edge
            if (accepted) begin
                rec_q.push_back(rec);
                last_q.push_back(is_last);
                theme_q.push_back(theme);
            end
            step();
        end
        col_valid = 1'b0;
    endtask

    // drain and then hold the fifo side closed until both halves can swap
    task automatic finish_packet();
        logic [31:0] b;
        while (rec_q.size() != 0) begin
            if (col_ready) report_protocol_error("col_ready high while a packet drains");
            step();
        end
        repeat (6) begin
            draw_bits(2, b);
            fb_swap_ok = (b[1:0] == 2'b11) ? 2'b01 : b[1:0];  // one half still busy
            step();
            if (col_ready) report_protocol_error("col_ready high before both halves were ready");
        end
        fb_swap_ok = 2'b11;
        step();
        if (!col_ready) report_protocol_error("col_ready stayed low after fb_swap_ok was 3");
        fb_swap_ok = 2'b00;
    endtask

    initial begin
        ray_col_t rec;
        rst_in     = 1'b1;
        col_valid  = 1'b0;
        col_data   = '0;
        col_last   = 1'b0;
        theme      = HEDGE;
        fb_swap_ok = 2'b00;
        pix_ready  = 1'b0;
        repeat (4) @(posedge pixel_clk_in);
        #2;
        rst_in    = 1'b0;
        pix_ready = 1'b1;
        if (pix_valid !== 1'b0 || col_ready !== 1'b1) begin
            report_protocol_error("pix_valid or col_ready wrong right after reset");
        end
        for (int p = 0; p < NUM_PACKETS; p++) begin
            theme        = theme_t'(p);     // each theme set while the DUT is idle
            ready_random = (p != 0);        // first packet at full rate
            for (int c = 0; c < COLS_PER_PACKET; c++) begin
                make_record(p * COLS_PER_PACKET + c, rec);
                send_col(rec, c == COLS_PER_PACKET - 1);
            end
            finish_packet();
        end
        if (pix_count != NUM_COLS * SCREEN_HEIGHT) begin
            report_protocol_error("pixel count does not match the records sent");
        end
        print_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pixel_clk_in);
        $display("watchdog: run still going after %0d cycles, the DUT stopped moving",
                 WATCHDOG_CYCLES);
        print_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* logic/column_flattener.sv */
`timescale 1ns/1ps

module column_flattener #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic                   pixel_clk_in,
    input  logic                   rst_in,
    // from the ray-march fifo
    input  logic                   col_valid,
    output logic                   col_ready,
    input  raster_pkg::ray_col_t   col_data,
    input  logic                   col_last,
    input  palette_pkg::theme_t    theme,       // changes only between frames
    input  logic [1:0]             fb_swap_ok,
    // to the frame buffer
    output logic                   pix_valid,
    output raster_pkg::fb_pixel_t  pix_data,
    input  logic                   pix_ready
);
    import raster_pkg::*;
    import palette_pkg::*;

    ray_col_t    cur_col;
    row_t        row;
    logic        row_valid;
    logic        row_last;
    logic        row_ready;
    region_t     region;
    colour_t     sky;
    colour_t     ground;
    pixel_word_t wall_pix;

    column_sequencer #(
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) u_sequencer (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .col_valid    (col_valid),
        .col_ready    (col_ready),
        .col_data     (col_data),
        .col_last     (col_last),
        .fb_swap_ok   (fb_swap_ok),
        .cur_col      (cur_col),
        .row          (row),
        .row_valid    (row_valid),
        .row_last     (row_last),
        .row_ready    (row_ready)
    );

    // span and palette both work off the held record in parallel
    wall_span #(
        .SCREEN_HEIGHT (SCREEN_HEIGHT)
    ) u_span (
        .line_height (cur_col.line_height),
        .row         (row),
        .region      (region)
    );

    wall_palette u_palette (
        .cur_col  (cur_col),
        .theme    (theme),
        .sky      (sky),
        .ground   (ground),
        .wall_pix (wall_pix)
    );

    pixel_assembler #(
        .SCREEN_WIDTH (SCREEN_WIDTH)
    ) u_assembler (
        .pixel_clk_in (pixel_clk_in),
        .rst_in       (rst_in),
        .region       (region),
        .sky          (sky),
        .ground       (ground),
        .wall_pix     (wall_pix),
        .col          (cur_col.col),
        .row          (row),
        .row_valid    (row_valid),
        .row_last     (row_last),
        .row_ready    (row_ready),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .pix_ready    (pix_ready)
    );

endmodule

/* logic/pixel_assembler.sv */
`timescale 1ns/1ps

module pixel_assembler #(
    parameter int SCREEN_WIDTH = 320
) (
    input  logic                     pixel_clk_in,
    input  logic                     rst_in,
    input  palette_pkg::region_t     region,
    input  palette_pkg::colour_t     sky,
    input  palette_pkg::colour_t     ground,
    input  raster_pkg::pixel_word_t  wall_pix,
    input  raster_pkg::col_t         col,
    input  raster_pkg::row_t         row,
    input  logic                     row_valid,
    input  logic                     row_last,
    output logic                     row_ready,
    // frame buffer side
    output logic                     pix_valid,
    output raster_pkg::fb_pixel_t    pix_data,
    input  logic                     pix_ready
);
    import raster_pkg::*;
    import palette_pkg::*;

    pixel_word_t pix_sel;
    fb_addr_t    addr;
    logic        row_xfer;

    // backdrop pixels are never shaded
    always_comb begin
        case (region)
            CEILING: pix_sel = '{shade: 1'b0, colour: sky};
            FLOOR:   pix_sel = '{shade: 1'b0, colour: ground};
            default: pix_sel = wall_pix;
        endcase
    end

    // row-major frame buffer, 179*320+319 still fits 16 bits
    assign addr = fb_addr_t'(col) + fb_addr_t'(row) * fb_addr_t'(SCREEN_WIDTH);

    // take a new row when the register is empty or being drained this cycle
    assign row_ready = !pix_valid || pix_ready;
    assign row_xfer  = row_valid && row_ready;

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            pix_valid <= 1'b0;
        end else if (row_xfer) begin
            pix_valid <= 1'b1;
        end else if (pix_ready) begin
            pix_valid <= 1'b0;   // drained with nothing behind it
        end
    end

    // output payload holds while stalled
    always_ff @(posedge pixel_clk_in) begin
        if (row_xfer) begin
            pix_data.addr  <= addr;
            pix_data.pixel <= pix_sel;
            pix_data.last  <= row_last;
        end
    end

endmodule

/* logic/wall_palette.sv */
`timescale 1ns/1ps

module wall_palette (
    input  raster_pkg::ray_col_t     cur_col,
    input  palette_pkg::theme_t      theme,
    output palette_pkg::colour_t     sky,
    output palette_pkg::colour_t     ground,
    output raster_pkg::pixel_word_t  wall_pix
);
    import palette_pkg::*;

    colour_t wall_colour;

    // theme picks the backdrop
    always_comb begin
        case (theme)
            HEDGE: begin
                sky    = SKY_HEDGE;
                ground = GROUND_HEDGE;
            end
            PIGS, DINO: begin
                sky    = SKY_WARM;
                ground = GROUND_WARM;
            end
            NEON: begin
                sky    = NEON_BACKDROP;
                ground = NEON_BACKDROP;
            end
            default: begin
                sky    = SKY_HEDGE;
                ground = GROUND_HEDGE;
            end
        endcase
    end

    // map value picks the wall face, former texture ids end up solid
    always_comb begin
        case (cur_col.map_val)
            MAP_EMPTY:            wall_colour = sky;          // open cell shows sky
            MAP_SOLID:            wall_colour = SOLID_WALL;
            MAP_NEON_FIRST:       wall_colour = NEON_YELLOW;
            MAP_NEON_FIRST + 5'd1: wall_colour = NEON_BLUE;
            MAP_NEON_FIRST + 5'd2: wall_colour = NEON_GREEN;
            MAP_NEON_LAST:        wall_colour = NEON_PINK;
            default:              wall_colour = SOLID_WALL;
        endcase
    end

    // y side hits are drawn darker, except where there is no wall at all
    assign wall_pix.shade  = (cur_col.map_val == MAP_EMPTY) ? 1'b0 : cur_col.y_side;
    assign wall_pix.colour = wall_colour;

endmodule

/* logic/wall_span.sv */
`timescale 1ns/1ps

module wall_span #(
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic [7:0]            line_height,
    input  raster_pkg::row_t      row,
    output palette_pkg::region_t  region
);
    import palette_pkg::*;

    localparam int HALF_SCREEN = SCREEN_HEIGHT / 2;

    // 9 bits so the sum can exceed the screen before clamping
    logic [8:0] half_line;
    logic [8:0] draw_start;
    logic [8:0] draw_end_raw;
    logic [8:0] draw_end;
    logic [8:0] row_w;

    assign half_line = {2'b00, line_height[7:1]};  // half of the line height
    assign row_w     = {1'b0, row};

    // wall centred on the half height, clamped to the screen
    assign draw_start   = (half_line >= 9'(HALF_SCREEN)) ? 9'd0 : 9'(HALF_SCREEN) - half_line;
    assign draw_end_raw = 9'(HALF_SCREEN) + half_line;
    assign draw_end     = (draw_end_raw > 9'(SCREEN_HEIGHT)) ? 9'(SCREEN_HEIGHT) : draw_end_raw;

    always_comb begin
        if (row_w < draw_start) begin
            region = CEILING;
        end else if (row_w >= draw_end) begin
            region = FLOOR;   // height 0 puts the whole lower half here
        end else begin
            region = WALL;
        end
    end

endmodule

/* logic/column_sequencer.sv */
`timescale 1ns/1ps

module column_sequencer #(
    parameter int SCREEN_HEIGHT = 180
) (
    input  logic                  pixel_clk_in,
    input  logic                  rst_in,
    // ray-march fifo side
    input  logic                  col_valid,
    output logic                  col_ready,
    input  raster_pkg::ray_col_t  col_data,
    input  logic                  col_last,     // record closes the frame packet
    input  logic [1:0]            fb_swap_ok,   // one bit per frame buffer half
    // row stream to the assembler
    output raster_pkg::ray_col_t  cur_col,
    output raster_pkg::row_t      row,
    output logic                  row_valid,
    output logic                  row_last,
    input  logic                  row_ready
);
    import raster_pkg::*;

    typedef enum logic [1:0] {
        WAIT_COL,   // ready for the next record
        WALK_ROWS,  // stepping through the rows of cur_col
        WAIT_SWAP   // packet done, hold off until both halves can switch
    } seq_state_t;

    localparam row_t LAST_ROW = row_t'(SCREEN_HEIGHT - 1);

    seq_state_t state;
    logic       last_q;     // last flag of the held record
    logic       col_xfer;
    logic       row_xfer;
    logic       final_row;

    assign col_ready = (state == WAIT_COL);   // high straight out of reset
    assign row_valid = (state == WALK_ROWS);
    assign col_xfer  = col_valid && col_ready;
    assign row_xfer  = row_valid && row_ready;
    assign final_row = (row == LAST_ROW);
    assign row_last  = row_valid && last_q && final_row;

    // record payload, only loads on an accepted handshake
    always_ff @(posedge pixel_clk_in) begin
        if (col_xfer) begin
            cur_col <= col_data;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state  <= WAIT_COL;
            row    <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                WAIT_COL: begin
                    if (col_xfer) begin
                        last_q <= col_last;
                        row    <= '0;         // every column starts at the top
                        state  <= WALK_ROWS;
                    end
                end

                WALK_ROWS: begin
                    if (row_xfer) begin
                        if (final_row) begin
                            row   <= '0;
                            // a last record waits for the buffer swap
                            state <= last_q ? WAIT_SWAP : WAIT_COL;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end
                end

                WAIT_SWAP: begin
                    if (fb_swap_ok == 2'b11) begin  // both halves ready
                        state <= WAIT_COL;
                    end
                end

                default: state <= WAIT_COL;
            endcase
        end
    end

endmodule

/* logic/palette_pkg.sv */
package palette_pkg;

    typedef logic [7:0] colour_t;  // palette index

    // per-map colour theme, neon moved to 2 so it fits the 2-bit select
    typedef enum logic [1:0] {
        HEDGE = 2'd0,
        PIGS  = 2'd1,
        NEON  = 2'd2,
        DINO  = 2'd3
    } theme_t;

    // vertical region of a row within its column
    typedef enum logic [1:0] {
        CEILING = 2'd0,
        WALL    = 2'd1,
        FLOOR   = 2'd2
    } region_t;

    // sky and ground per theme
    localparam colour_t SKY_HEDGE     = 8'd249;
    localparam colour_t GROUND_HEDGE  = 8'd239;
    localparam colour_t SKY_WARM      = 8'd38;   // pigs and dino share these
    localparam colour_t GROUND_WARM   = 8'd45;
    localparam colour_t NEON_BACKDROP = 8'd0;    // black sky and floor

    // wall colours
    localparam colour_t SOLID_WALL  = 8'd14;
    localparam colour_t NEON_YELLOW = 8'd21;
    localparam colour_t NEON_BLUE   = 8'd48;
    localparam colour_t NEON_GREEN  = 8'd32;
    localparam colour_t NEON_PINK   = 8'd181;

    // map cell values with a meaning of their own
    localparam logic [4:0] MAP_EMPTY      = 5'd0;
    localparam logic [4:0] MAP_SOLID      = 5'd1;
    localparam logic [4:0] MAP_NEON_FIRST = 5'd23;  // yellow, blue, green, pink in order
    localparam logic [4:0] MAP_NEON_LAST  = 5'd26;

endpackage

/* logic/raster_pkg.sv */
package raster_pkg;

    // screen geometry
    typedef logic [8:0]  col_t;      // 0..319 for a 320 wide screen
    typedef logic [7:0]  row_t;      // 0..179 for a 180 high screen
    typedef logic [15:0] fb_addr_t;  // col + row*width, fits 320x180
    typedef logic [4:0]  map_val_t;  // map cell value from the grid rom

    // one ray-column record as it sits in the ray-march fifo
    // 9 + 8 + 1 + 5 + 16 = 39 bits, col in the top bits
    typedef struct packed {
        col_t        col;          // screen column of this ray
        logic [7:0]  line_height;  // wall line height in rows
        logic        y_side;       // 1 = ray hit a y side wall
        map_val_t    map_val;      // cell value at the hit
        logic [15:0] wall_x;       // hit position on the wall face, only used for texturing
    } ray_col_t;

    // 9-bit pixel word stored in the frame buffer
    typedef struct packed {
        logic       shade;   // darken bit, set on y side hits
        logic [7:0] colour;  // palette index
    } pixel_word_t;

    // one beat towards the frame buffer
    typedef struct packed {
        fb_addr_t    addr;   // where the pixel lands
        pixel_word_t pixel;
        logic        last;   // final pixel of the frame packet
    } fb_pixel_t;

endpackage
